// ==== logic/bexec_pkg.sv ====
//--------------------
// Back-end execution package
// Widths, opcodes and latencies shared by the integer back end
//--------------------
package bexec_pkg;

  //--------------------
  // Word types
  //--------------------

  typedef logic [31:0] data_t;
  typedef logic [31:0] pc_t;

  // Wraps at 256, so at most 256 operations in flight
  typedef logic [7:0]  seq_t;

  typedef logic [4:0]  reg_addr_t;

  //--------------------
  // Operations
  //--------------------

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_MUL = 3'd4
  } opcode_t;

  // Cycles from start to valid for a multiply, other ops take 1
  localparam int MUL_LATENCY = 4;

  // Pipe count unless the top level says otherwise
  localparam int NUM_PIPES_DEFAULT = 3;

endpackage

// ==== logic/dispatch_unit.sv ====
//--------------------
// Dispatch unit
// Tags each issued op with a sequence number and
// starts it on the lowest-numbered idle execute pipe
//--------------------
`timescale 1ns/1ps

module dispatch_unit #(
  parameter int NUM_PIPES = bexec_pkg::NUM_PIPES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,

  // Issue strobe from outside
  input  logic                  issue_valid,
  input  bexec_pkg::pc_t        issue_pc,
  input  bexec_pkg::opcode_t    issue_op,
  input  bexec_pkg::data_t      issue_a,
  input  bexec_pkg::data_t      issue_b,
  input  bexec_pkg::reg_addr_t  issue_waddr,
  input  logic                  issue_wen,
  output logic                  issue_ready,

  // Start strobes and shared operation buses to the pipes
  input  logic [NUM_PIPES-1:0]  pipe_idle,
  output logic [NUM_PIPES-1:0]  pipe_start,
  output bexec_pkg::pc_t        start_pc,
  output bexec_pkg::opcode_t    start_op,
  output bexec_pkg::data_t      start_a,
  output bexec_pkg::data_t      start_b,
  output bexec_pkg::seq_t       start_seq,
  output bexec_pkg::reg_addr_t  start_waddr,
  output logic                  start_wen
);

  import bexec_pkg::*;

  seq_t                 seq_q;
  logic [NUM_PIPES-1:0] pick;
  logic                 accept;

  //--------------------
  // Lowest idle pipe
  //--------------------

  always_comb begin : pick_lowest
    logic found;
    found = 1'b0;
    pick  = '0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      if (pipe_idle[i] && !found) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
  end

  assign issue_ready = |pipe_idle;
  assign accept      = issue_valid && issue_ready;
  assign pipe_start  = accept ? pick : '0;

  // Operation fields go to every pipe, only the started one latches them
  assign start_pc    = issue_pc;
  assign start_op    = issue_op;
  assign start_a     = issue_a;
  assign start_b     = issue_b;
  assign start_seq   = seq_q;
  assign start_waddr = issue_waddr;
  assign start_wen   = issue_wen;

  // Sequence tag, one step per accepted issue
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_q <= '0;
    end else if (accept) begin
      seq_q <= seq_q + 1'b1;
    end
  end

  //--------------------
  // Checks
  //--------------------

  // Outside must wait for a free pipe
  issue_needs_ready: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> issue_ready)
    else $error("dispatch: issue strobe while no pipe is idle");

  // A started pipe has left idle by the next cycle
  start_leaves_idle: assert property (@(posedge clk) disable iff (rst)
    (|pipe_start) |=> ((pipe_idle & $past(pipe_start)) == '0))
    else $error("dispatch: started pipe still idle");

endmodule

// ==== logic/exec_pipe.sv ====
//--------------------
// Execute pipe
// Single-cycle ALU plus multi-cycle multiply, result held
// until writeback grants it
//--------------------
`timescale 1ns/1ps

module exec_pipe (
  input  logic                  clk,
  input  logic                  rst,

  // Start strobe and operation from dispatch
  input  logic                  start,
  input  bexec_pkg::pc_t        start_pc,
  input  bexec_pkg::opcode_t    start_op,
  input  bexec_pkg::data_t      start_a,
  input  bexec_pkg::data_t      start_b,
  input  bexec_pkg::seq_t       start_seq,
  input  bexec_pkg::reg_addr_t  start_waddr,
  input  logic                  start_wen,
  output logic                  idle,

  // Result handshake toward writeback
  input  logic                  ready,
  output logic                  valid,
  output bexec_pkg::pc_t        res_pc,
  output bexec_pkg::seq_t       res_seq,
  output bexec_pkg::reg_addr_t  res_waddr,
  output bexec_pkg::data_t      res_wdata,
  output logic                  res_wen
);

  import bexec_pkg::*;

  localparam int CNT_W = $clog2(MUL_LATENCY);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] count;
  logic             take;
  logic             mul_last;
  data_t            a_q;
  data_t            b_q;

  function automatic data_t alu_result(opcode_t op, data_t a, data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  assign idle     = (state == IDLE);
  assign valid    = (state == DONE);
  assign take     = start && idle;
  assign mul_last = (state == BUSY) && (count == '0);

  //--------------------
  // FSM
  //--------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (take && start_op == OP_MUL) begin
            state <= BUSY;
            // One cycle to enter BUSY, one to reach DONE
            count <= CNT_W'(MUL_LATENCY - 2);
          end else if (take) begin
            state <= DONE;
          end
        end
        BUSY: begin
          if (count == '0) begin
            state <= DONE;
          end else begin
            count <= count - 1'b1;
          end
        end
        DONE: begin
          if (ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operation latch and result hold
  always_ff @(posedge clk) begin
    if (take) begin
      res_pc    <= start_pc;
      res_seq   <= start_seq;
      res_waddr <= start_waddr;
      res_wen   <= start_wen;
      a_q       <= start_a;
      b_q       <= start_b;
      res_wdata <= alu_result(start_op, start_a, start_b);
    end else if (mul_last) begin
      res_wdata <= a_q * b_q;
    end
  end

  //--------------------
  // Checks
  //--------------------

  start_only_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> idle)
    else $error("exec_pipe: start while not idle");

endmodule

// ==== logic/rr_arbiter.sv ====
//--------------------
// Round-robin arbiter
// First requester at or after a rotating pointer wins
//--------------------
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int NUM_REQ = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [NUM_REQ-1:0] req,
  output logic [NUM_REQ-1:0] gnt
);

  localparam int PTR_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [PTR_W-1:0] ptr;
  int               gnt_idx;

  // Scan from the pointer, wrapping once around
  always_comb begin : scan
    int idx;
    gnt     = '0;
    gnt_idx = 0;
    for (int k = NUM_REQ - 1; k >= 0; k--) begin
      idx = int'(ptr) + k;
      if (idx >= NUM_REQ) begin
        idx = idx - NUM_REQ;
      end
      if (req[idx]) begin
        gnt     = '0;
        gnt[idx] = 1'b1;
        gnt_idx = idx;
      end
    end
  end

  // Winner gets lowest priority next time
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (|gnt) begin
      ptr <= (gnt_idx == NUM_REQ - 1) ? '0 : PTR_W'(gnt_idx + 1);
    end
  end

  grant_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(gnt) && ((gnt & ~req) == '0))
    else $error("rr_arbiter: grant not one-hot or not requested");

endmodule

// ==== logic/writeback_unit.sv ====
//--------------------
// Writeback unit
// Picks one finished pipe per cycle, reports it as a
// completion now and as a commit one cycle later
//--------------------
`timescale 1ns/1ps

module writeback_unit #(
  parameter int NUM_PIPES = bexec_pkg::NUM_PIPES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,

  // Results from the pipes
  input  logic [NUM_PIPES-1:0]  pipe_valid,
  input  bexec_pkg::pc_t        pipe_pc    [NUM_PIPES],
  input  bexec_pkg::seq_t       pipe_seq   [NUM_PIPES],
  input  bexec_pkg::reg_addr_t  pipe_waddr [NUM_PIPES],
  input  bexec_pkg::data_t      pipe_wdata [NUM_PIPES],
  input  logic [NUM_PIPES-1:0]  pipe_wen,
  output logic [NUM_PIPES-1:0]  pipe_ready,

  // Completion strobe
  output logic                  complete_valid,
  output bexec_pkg::seq_t       complete_seq,
  output bexec_pkg::reg_addr_t  complete_waddr,
  output bexec_pkg::data_t      complete_wdata,
  output logic                  complete_wen,

  // Commit strobe
  output logic                  commit_valid,
  output bexec_pkg::pc_t        commit_pc,
  output bexec_pkg::seq_t       commit_seq,
  output bexec_pkg::reg_addr_t  commit_waddr,
  output bexec_pkg::data_t      commit_wdata,
  output logic                  commit_wen
);

  import bexec_pkg::*;

  logic [NUM_PIPES-1:0] gnt;
  logic                 sel_valid;
  pc_t                  sel_pc;
  seq_t                 sel_seq;
  reg_addr_t            sel_waddr;
  data_t                sel_wdata;
  logic                 sel_wen;
  logic                 wen_kept;

  //--------------------
  // Arbitration
  //--------------------

  rr_arbiter #(
    .NUM_REQ (NUM_PIPES)
  ) arb_inst (
    .clk (clk),
    .rst (rst),
    .req (pipe_valid),
    .gnt (gnt)
  );

  // The grant doubles as the pipe's ready
  assign pipe_ready = gnt;

  // Mask with the grant and OR into one result
  always_comb begin
    sel_pc    = '0;
    sel_seq   = '0;
    sel_waddr = '0;
    sel_wdata = '0;
    sel_wen   = 1'b0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      sel_pc    = sel_pc    | (pipe_pc[i]    & {$bits(pc_t){gnt[i]}});
      sel_seq   = sel_seq   | (pipe_seq[i]   & {$bits(seq_t){gnt[i]}});
      sel_waddr = sel_waddr | (pipe_waddr[i] & {$bits(reg_addr_t){gnt[i]}});
      sel_wdata = sel_wdata | (pipe_wdata[i] & {$bits(data_t){gnt[i]}});
      sel_wen   = sel_wen   | (pipe_wen[i]   & gnt[i]);
    end
  end

  assign sel_valid = |gnt;

  // Register 0 is never written
  assign wen_kept = sel_wen && (sel_waddr != '0);

  //--------------------
  // Completion and commit
  //--------------------

  assign complete_valid = sel_valid;
  assign complete_seq   = sel_seq;
  assign complete_waddr = sel_waddr;
  assign complete_wdata = sel_wdata;
  assign complete_wen   = wen_kept;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
      commit_wen   <= 1'b0;
    end else begin
      commit_valid <= sel_valid;
      commit_wen   <= wen_kept;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_valid) begin
      commit_pc    <= sel_pc;
      commit_seq   <= sel_seq;
      commit_waddr <= sel_waddr;
      commit_wdata <= sel_wdata;
    end
  end

endmodule

// ==== logic/backend_top.sv ====
//--------------------
// Back-end top level
// Dispatch, the execute pipe array and writeback
//--------------------
`timescale 1ns/1ps

module backend_top #(
  parameter int NUM_PIPES = bexec_pkg::NUM_PIPES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  issue_valid,
  input  bexec_pkg::pc_t        issue_pc,
  input  bexec_pkg::opcode_t    issue_op,
  input  bexec_pkg::data_t      issue_a,
  input  bexec_pkg::data_t      issue_b,
  input  bexec_pkg::reg_addr_t  issue_waddr,
  input  logic                  issue_wen,
  output logic                  issue_ready,

  output logic                  complete_valid,
  output bexec_pkg::seq_t       complete_seq,
  output bexec_pkg::reg_addr_t  complete_waddr,
  output bexec_pkg::data_t      complete_wdata,
  output logic                  complete_wen,

  output logic                  commit_valid,
  output bexec_pkg::pc_t        commit_pc,
  output bexec_pkg::seq_t       commit_seq,
  output bexec_pkg::reg_addr_t  commit_waddr,
  output bexec_pkg::data_t      commit_wdata,
  output logic                  commit_wen
);

  import bexec_pkg::*;

  // Dispatch to pipes
  logic [NUM_PIPES-1:0] pipe_idle;
  logic [NUM_PIPES-1:0] pipe_start;
  pc_t                  start_pc;
  opcode_t              start_op;
  data_t                start_a;
  data_t                start_b;
  seq_t                 start_seq;
  reg_addr_t            start_waddr;
  logic                 start_wen;

  // Pipes to writeback
  logic [NUM_PIPES-1:0] pipe_valid;
  logic [NUM_PIPES-1:0] pipe_ready;
  pc_t                  pipe_pc    [NUM_PIPES];
  seq_t                 pipe_seq   [NUM_PIPES];
  reg_addr_t            pipe_waddr [NUM_PIPES];
  data_t                pipe_wdata [NUM_PIPES];
  logic [NUM_PIPES-1:0] pipe_wen;

  dispatch_unit #(
    .NUM_PIPES (NUM_PIPES)
  ) dispatch_inst (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_pc    (issue_pc),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_waddr (issue_waddr),
    .issue_wen   (issue_wen),
    .issue_ready (issue_ready),
    .pipe_idle   (pipe_idle),
    .pipe_start  (pipe_start),
    .start_pc    (start_pc),
    .start_op    (start_op),
    .start_a     (start_a),
    .start_b     (start_b),
    .start_seq   (start_seq),
    .start_waddr (start_waddr),
    .start_wen   (start_wen)
  );

  //--------------------
  // Execute pipe array
  //--------------------

  for (genvar g = 0; g < NUM_PIPES; g++) begin : g_pipe
    exec_pipe pipe_inst (
      .clk         (clk),
      .rst         (rst),
      .start       (pipe_start[g]),
      .start_pc    (start_pc),
      .start_op    (start_op),
      .start_a     (start_a),
      .start_b     (start_b),
      .start_seq   (start_seq),
      .start_waddr (start_waddr),
      .start_wen   (start_wen),
      .idle        (pipe_idle[g]),
      .ready       (pipe_ready[g]),
      .valid       (pipe_valid[g]),
      .res_pc      (pipe_pc[g]),
      .res_seq     (pipe_seq[g]),
      .res_waddr   (pipe_waddr[g]),
      .res_wdata   (pipe_wdata[g]),
      .res_wen     (pipe_wen[g])
    );
  end

  writeback_unit #(
    .NUM_PIPES (NUM_PIPES)
  ) writeback_inst (
    .clk            (clk),
    .rst            (rst),
    .pipe_valid     (pipe_valid),
    .pipe_pc        (pipe_pc),
    .pipe_seq       (pipe_seq),
    .pipe_waddr     (pipe_waddr),
    .pipe_wdata     (pipe_wdata),
    .pipe_wen       (pipe_wen),
    .pipe_ready     (pipe_ready),
    .complete_valid (complete_valid),
    .complete_seq   (complete_seq),
    .complete_waddr (complete_waddr),
    .complete_wdata (complete_wdata),
    .complete_wen   (complete_wen),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_seq     (commit_seq),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata),
    .commit_wen     (commit_wen)
  );

endmodule

// ==== tests/backend_tb.sv ====
//--------------------
// Back-end testbench
// Random and directed issue stimulus, reference model,
// seq-indexed scoreboard and completion/commit checks
//--------------------
`timescale 1ns/1ps

module backend_tb;

  import bexec_pkg::*;

  localparam int NUM_PIPES     = 3;
  localparam int READY_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int RANDOM_OPS    = 300;

  logic      clk;
  logic      rst;
  logic      issue_valid;
  pc_t       issue_pc;
  opcode_t   issue_op;
  data_t     issue_a;
  data_t     issue_b;
  reg_addr_t issue_waddr;
  logic      issue_wen;
  logic      issue_ready;
  logic      complete_valid;
  seq_t      complete_seq;
  reg_addr_t complete_waddr;
  data_t     complete_wdata;
  logic      complete_wen;
  logic      commit_valid;
  pc_t       commit_pc;
  seq_t      commit_seq;
  reg_addr_t commit_waddr;
  data_t     commit_wdata;
  logic      commit_wen;

  // Scoreboard, indexed by seq
  pc_t       exp_pc       [256];
  reg_addr_t exp_waddr    [256];
  data_t     exp_wdata    [256];
  logic      exp_wen      [256];
  logic      outstanding  [256];

  seq_t        next_seq;
  int          errors;
  int          issued;
  int          committed;
  logic        timed_out;
  logic        ready_dropped;
  logic [31:0] lfsr_state;

  // Last cycle's completion, for the commit check
  logic      prev_valid;
  seq_t      prev_seq;
  reg_addr_t prev_waddr;
  data_t     prev_wdata;
  logic      prev_wen;

  backend_top #(
    .NUM_PIPES (NUM_PIPES)
  ) backend_top_inst (
    .clk            (clk),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_op       (issue_op),
    .issue_a        (issue_a),
    .issue_b        (issue_b),
    .issue_waddr    (issue_waddr),
    .issue_wen      (issue_wen),
    .issue_ready    (issue_ready),
    .complete_valid (complete_valid),
    .complete_seq   (complete_seq),
    .complete_waddr (complete_waddr),
    .complete_wdata (complete_wdata),
    .complete_wen   (complete_wen),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_seq     (commit_seq),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata),
    .commit_wen     (commit_wen)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //--------------------
  // Helpers
  //--------------------

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Expected ALU or multiply result, low 32 bits
  function automatic data_t expected_result(opcode_t op, data_t a, data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_MUL:  return a * b;
      default: return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  function automatic int outstanding_count();
    int n;
    n = 0;
    for (int i = 0; i < 256; i++) begin
      if (outstanding[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Called on a falling edge, waits for a free pipe, then strobes one cycle
  task automatic issue_one(input opcode_t op, input data_t a, input data_t b,
                           input pc_t pc, input reg_addr_t waddr, input logic wen);
    int waited;
    waited = 0;
    if (!issue_ready) begin
      ready_dropped = 1'b1;
    end
    while (!issue_ready && waited < READY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!issue_ready) begin
      $display("error at %0t: issue_ready stayed low for %0d cycles", $time, waited);
      errors++;
      timed_out = 1'b1;
    end else begin
      issue_valid          = 1'b1;
      issue_op             = op;
      issue_a              = a;
      issue_b              = b;
      issue_pc             = pc;
      issue_waddr          = waddr;
      issue_wen            = wen;
      exp_pc[next_seq]     = pc;
      exp_waddr[next_seq]  = waddr;
      exp_wdata[next_seq]  = expected_result(op, a, b);
      exp_wen[next_seq]    = wen && (waddr != '0);
      outstanding[next_seq] = 1'b1;
      next_seq++;
      issued++;
      @(negedge clk);
      issue_valid = 1'b0;
    end
  endtask

  //--------------------
  // Output checks
  //--------------------

  always @(negedge clk) begin : compare_outputs
    if (rst) begin
      prev_valid = 1'b0;
    end else begin
      check_value("commit_valid", commit_valid, prev_valid);
      if (prev_valid && commit_valid) begin
        check_value("commit_seq", commit_seq, prev_seq);
        check_value("commit_waddr", commit_waddr, prev_waddr);
        check_value("commit_wdata", commit_wdata, prev_wdata);
        check_value("commit_wen", commit_wen, prev_wen);
        check_value("commit_pc", commit_pc, exp_pc[prev_seq]);
        committed++;
      end
      if (complete_valid) begin
        if (!outstanding[complete_seq]) begin
          $display("error at %0t: completion for seq %0d, which is not outstanding",
                   $time, complete_seq);
          errors++;
        end else begin
          check_value("complete_waddr", complete_waddr, exp_waddr[complete_seq]);
          check_value("complete_wdata", complete_wdata, exp_wdata[complete_seq]);
          check_value("complete_wen", complete_wen, exp_wen[complete_seq]);
          outstanding[complete_seq] = 1'b0;
        end
      end
      prev_valid = complete_valid;
      prev_seq   = complete_seq;
      prev_waddr = complete_waddr;
      prev_wdata = complete_wdata;
      prev_wen   = complete_wen;
    end
  end

  //--------------------
  // Stimulus
  //--------------------

  initial begin : stimulus
    logic [31:0] r;
    opcode_t     op;
    data_t       a;
    data_t       b;
    pc_t         pc;
    reg_addr_t   waddr;
    logic        wen;
    int          waited;

    rst           = 1'b1;
    issue_valid   = 1'b0;
    issue_pc      = '0;
    issue_op      = OP_ADD;
    issue_a       = '0;
    issue_b       = '0;
    issue_waddr   = '0;
    issue_wen     = 1'b0;
    next_seq      = '0;
    errors        = 0;
    issued        = 0;
    committed     = 0;
    timed_out     = 1'b0;
    ready_dropped = 1'b0;
    lfsr_state    = 32'h9c35_5913;
    for (int i = 0; i < 256; i++) begin
      outstanding[i] = 1'b0;
    end

    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Quiet back end before the first issue
    repeat (4) begin
      @(negedge clk);
      check_value("issue_ready", issue_ready, 32'd1);
      check_value("complete_valid", complete_valid, 32'd0);
      check_value("commit_valid", commit_valid, 32'd0);
    end

    // Writes to register 0 come out with wen low
    issue_one(OP_ADD, 32'h0000_0011, 32'h0000_0022, 32'h0000_0100, 5'd0, 1'b1);
    issue_one(OP_MUL, 32'h0000_1234, 32'h0000_5678, 32'h0000_0104, 5'd0, 1'b1);
    idle_cycles(8);

    // Multiply plus a late add, both finish in the same cycle
    issue_one(OP_MUL, 32'd7, 32'd9, 32'h0000_0108, 5'd5, 1'b1);
    idle_cycles(MUL_LATENCY - 2);
    issue_one(OP_ADD, 32'hffff_fff0, 32'h0000_0020, 32'h0000_010c, 5'd6, 1'b1);
    idle_cycles(8);

    // Multiply burst fills every pipe
    ready_dropped = 1'b0;
    for (int k = 0; k < NUM_PIPES + 3; k++) begin
      issue_one(OP_MUL, 32'h0001_0003 + k, 32'h0000_0105 * (k + 1),
                32'h0000_0200 + 4 * k, 5'(k + 1), 1'b1);
    end
    if (!ready_dropped && !timed_out) begin
      $display("error at %0t: issue_ready never dropped during the multiply burst", $time);
      errors++;
    end

    // Random traffic
    for (int n = 0; n < RANDOM_OPS && !timed_out; n++) begin
      draw_bits(3, r);
      op = opcode_t'(3'(r % 5));
      draw_bits(32, r);
      a = r;
      draw_bits(32, r);
      b = r;
      draw_bits(5, r);
      waddr = r[4:0];
      draw_bits(1, r);
      wen = r[0];
      draw_bits(30, r);
      pc = {r[29:0], 2'b00};
      issue_one(op, a, b, pc, waddr, wen);
      draw_bits(2, r);
      idle_cycles(int'(r[1:0]));
    end

    // Drain, sampled on the rising edge away from the checker
    waited = 0;
    while ((outstanding_count() != 0 || committed != issued) && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (outstanding_count() != 0 || committed != issued) begin
      $display("error at %0t: drain timed out, %0d outstanding, %0d of %0d committed",
               $time, outstanding_count(), committed, issued);
      errors++;
    end

    $display("errors: %0d  issued: %0d  committed: %0d", errors, issued, committed);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
logic/bexec_pkg.sv
logic/dispatch_unit.sv
logic/exec_pipe.sv
logic/rr_arbiter.sv
logic/writeback_unit.sv
logic/backend_top.sv
tests/backend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the back end with Verilator, run the testbench and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=backend_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module backend_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

grep -qx "Test completed successfully" "$LOG_FILE"
if [ $? -ne 0 ]; then
  echo "FAIL: pass message not found in $LOG_FILE"
  exit 1
fi

echo "PASS"
exit 0
